// File: bench/hisClockGen.sv
module hisClockGen (
    output logic clk,
    output logic arstN
);

    // 20-unit period, first rising edge at 10
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // held low over two rising edges, released on a falling edge
    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

// File: bench/hisTb.sv
module hisTb;
    import hisPkg::*;

    logic                clk;
    logic                arstN;
    logic [SAMPLE_W-1:0] sample;
    logic                wrEn;
    logic                busy;
    logic                resultValid;
    resultT              result;

    // samples of the coarse and fine pass of one run
    logic [SAMPLE_W-1:0] coarseQ[$];
    logic [SAMPLE_W-1:0] fineQ[$];

    int errors;

    hisClockGen clockGen0 (
        .clk   (clk),
        .arstN (arstN)
    );

    hisTop dut0 (
        .clk         (clk),
        .arstN       (arstN),
        .sample      (sample),
        .wrEn        (wrEn),
        .busy        (busy),
        .resultValid (resultValid),
        .result      (result)
    );

    task automatic stopRun(input string line);
        errors++;
        $display("%s", line);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic checkLevel(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic checkResult(input resultT got, input resultT exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf(
                "ERR %0t: %s got coarse %0d fine %0d est %0d count %0d, %s %0d %0d %0d %0d",
                $time, what, got.coarseBin, got.fineBin, got.estimate, got.peakCount,
                "expected", exp.coarseBin, exp.fineBin, exp.estimate, exp.peakCount));
        end
    endtask

    // expected result straight from the binning rules
    task automatic modelResult(output resultT exp);
        int coarseCnt[NUM_BINS];
        int fineCnt[NUM_BINS];
        int cBin;
        int fBin;
        int thMinus;
        int offs;
        for (int i = 0; i < NUM_BINS; i++) begin
            coarseCnt[i] = 0;
            fineCnt[i] = 0;
        end
        // 16 values per coarse bin
        foreach (coarseQ[k]) begin
            coarseCnt[int'(coarseQ[k]) / 16]++;
        end
        // lowest index wins a tie
        cBin = 0;
        for (int i = 1; i < NUM_BINS; i++) begin
            if (coarseCnt[i] > coarseCnt[cBin]) begin
                cBin = i;
            end
        end
        thMinus = cBin * 16 - WIN_OFFSET;
        if (thMinus < 0) begin
            thMinus = 0;
        end
        if (thMinus > WIN_MAX) begin
            thMinus = WIN_MAX;
        end
        // only the 16 values from thMinus up are counted
        foreach (fineQ[k]) begin
            offs = int'(fineQ[k]) - thMinus;
            if (offs >= 0 && offs < NUM_BINS) begin
                fineCnt[offs]++;
            end
        end
        fBin = 0;
        for (int i = 1; i < NUM_BINS; i++) begin
            if (fineCnt[i] > fineCnt[fBin]) begin
                fBin = i;
            end
        end
        exp.coarseBin = BIN_W'(cBin);
        exp.fineBin   = BIN_W'(fBin);
        exp.estimate  = SAMPLE_W'(thMinus + fBin);
        exp.peakCount = COUNT_W'(fineCnt[fBin]);
    endtask

    // one pass of ACQ_LEN strobes, then ride out the scan
    task automatic drivePass(input bit finePass, input bit junk);
        logic [SAMPLE_W-1:0] s;
        for (int k = 0; k < ACQ_LEN; k++) begin
            s = finePass ? fineQ[k] : coarseQ[k];
            @(negedge clk);
            sample = s;
            wrEn   = 1'b1;
        end
        @(negedge clk);
        // last capture edge starts the scan
        checkLevel(busy, 1'b1, "busy after the last sample");
        while (busy) begin
            // strobes here should be ignored
            wrEn   = junk;
            sample = junk ? SAMPLE_W'($urandom) : '0;
            @(negedge clk);
        end
        wrEn   = 1'b0;
        sample = '0;
    endtask

    task automatic waitResult(output resultT got);
        int waited;
        waited = 0;
        while (resultValid !== 1'b1) begin
            if (waited == 4) begin
                stopRun("no result arrived after the fine scan ended");
            end
            @(negedge clk);
            waited++;
        end
        checkLevel(busy, 1'b0, "busy with the result");
        got = result;
    endtask

    // coarse pass, fine pass, result against the model
    task automatic runCase(input bit junk, input string name, output resultT got);
        resultT exp;
        drivePass(1'b0, junk);
        // window register is loaded before the first fine capture
        drivePass(1'b1, junk);
        waitResult(got);
        modelResult(exp);
        checkResult(got, exp, name);
    endtask

    task automatic pushSamples(input bit finePass, input int value, input int n);
        for (int k = 0; k < n; k++) begin
            if (finePass) begin
                fineQ.push_back(SAMPLE_W'(value));
            end else begin
                coarseQ.push_back(SAMPLE_W'(value));
            end
        end
    endtask

    function automatic logic [SAMPLE_W-1:0] clusterSample(input int center, input int spread);
        int v;
        // about one in eight is an outlier anywhere in range
        if (($urandom % 8) == 0) begin
            v = int'($urandom % 256);
        end else begin
            v = center + int'($urandom % (2 * spread + 1)) - spread;
        end
        if (v < 0) begin
            v = 0;
        end
        if (v > 255) begin
            v = 255;
        end
        return SAMPLE_W'(v);
    endfunction

    task automatic testResetState();
        resultT got;
        checkLevel(busy, 1'b0, "busy after reset");
        checkLevel(resultValid, 1'b0, "resultValid after reset");
        coarseQ.delete();
        fineQ.delete();
        pushSamples(1'b0, 50, ACQ_LEN);
        // flat fine histogram, two hits per value
        for (int v = 40; v < 56; v++) begin
            pushSamples(1'b1, v, 2);
        end
        runCase(1'b0, "first pass after reset", got);
    endtask

    task automatic testSingleValue();
        resultT got;
        resultT exp;
        coarseQ.delete();
        fineQ.delete();
        pushSamples(1'b0, 100, ACQ_LEN);
        pushSamples(1'b1, 100, ACQ_LEN);
        runCase(1'b0, "single value", got);
        exp.coarseBin = 4'd6;
        exp.fineBin   = 4'd12;
        exp.estimate  = 8'd100;
        exp.peakCount = 6'd32;
        checkResult(got, exp, "single value numbers");
    endtask

    task automatic testTiesAndDrops();
        resultT got;
        coarseQ.delete();
        fineQ.delete();
        // bins 4 and 9 tie at 16 each
        for (int k = 0; k < ACQ_LEN / 2; k++) begin
            pushSamples(1'b0, 8'h95, 1);
            pushSamples(1'b0, 8'h45, 1);
        end
        // 204 lies outside the fine window but folds onto fine bin 4
        for (int k = 0; k < 12; k++) begin
            pushSamples(1'b1, 204, 1);
            pushSamples(1'b1, 60, 1);
        end
        pushSamples(1'b1, 60, ACQ_LEN - 24);
        runCase(1'b0, "ties and drops", got);
    endtask

    task automatic testClamping();
        resultT got;
        resultT exp;
        coarseQ.delete();
        fineQ.delete();
        pushSamples(1'b0, 3, ACQ_LEN);
        pushSamples(1'b1, 3, ACQ_LEN);
        runCase(1'b0, "low clamp", got);
        exp.coarseBin = 4'd0;
        exp.fineBin   = 4'd3;
        exp.estimate  = 8'd3;
        exp.peakCount = 6'd32;
        checkResult(got, exp, "low clamp numbers");
        // top coarse bin, 250 itself falls past the window end
        coarseQ.delete();
        fineQ.delete();
        pushSamples(1'b0, 250, ACQ_LEN);
        pushSamples(1'b1, 245, 20);
        pushSamples(1'b1, 250, 12);
        runCase(1'b0, "high end", got);
    endtask

    task automatic testBusyHandling();
        resultT got;
        coarseQ.delete();
        fineQ.delete();
        pushSamples(1'b0, 180, ACQ_LEN);
        pushSamples(1'b1, 177, ACQ_LEN);
        runCase(1'b1, "strobes while busy", got);
        // straight into the next run, bins must be clean
        coarseQ.delete();
        fineQ.delete();
        pushSamples(1'b0, 20, ACQ_LEN);
        pushSamples(1'b1, 22, ACQ_LEN / 2);
        pushSamples(1'b1, 25, ACQ_LEN / 2);
        runCase(1'b0, "back to back run", got);
    endtask

    task automatic testRandomMix();
        resultT got;
        int center;
        for (int r = 0; r < 4; r++) begin
            coarseQ.delete();
            fineQ.delete();
            center = int'($urandom % 256);
            for (int k = 0; k < ACQ_LEN; k++) begin
                coarseQ.push_back(clusterSample(center, 6));
                fineQ.push_back(clusterSample(center, 10));
            end
            runCase(1'b0, "random mix", got);
        end
    endtask

    // eleven runs over all tests
    initial begin : watchdog
        longint limit;
        limit = 11 * (2 * ACQ_LEN + 2 * NUM_BINS + 10) * 20;
        #(limit);
        stopRun("timeout: no result arrived before the time limit ran out");
    end

    // a bound assertion failure ends the run too
    initial begin : assertWatch
        wait (dut0.hisTopProps0.failCount != 0);
        stopRun("an assertion bound to the DUT failed");
    end

    initial begin : mainSeq
        errors = 0;
        wrEn   = 1'b0;
        sample = '0;
        void'($urandom(32'ha13317f8));
        wait (arstN === 1'b1);
        @(negedge clk);
        testResetState();
        testSingleValue();
        testTiesAndDrops();
        testClamping();
        testBusyHandling();
        testRandomMix();
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: bench/hisTop_props.sv
module hisTopProps (
    input logic clk,
    input logic arstN,
    input logic busy,
    input logic pendValid,
    input logic resultValid
);
    import hisPkg::*;

    // assertion failures so far, watched from the testbench
    int failCount = 0;

    // one-cycle result strobe
    resultPulse: assert property (
        @(posedge clk) disable iff (!arstN)
        resultValid |=> !resultValid
    ) else begin
        failCount++;
        $error("resultValid held for more than one cycle");
    end

    // past the first scan cycle no increment may be pending
    noWriteWhileBusy: assert property (
        @(posedge clk) disable iff (!arstN)
        (busy && $past(busy)) |-> !pendValid
    ) else begin
        failCount++;
        $error("bin write taken while busy");
    end

    // a scan is exactly one read per bin
    busyLength: assert property (
        @(posedge clk) disable iff (!arstN)
        $rose(busy) |-> busy [*NUM_BINS] ##1 !busy
    ) else begin
        failCount++;
        $error("busy length differs from one scan");
    end

endmodule

bind hisTop hisTopProps hisTopProps0 (
    .clk         (clk),
    .arstN       (arstN),
    .busy        (busy),
    // increment queued inside the builder
    .pendValid   (hisBuilder0.pendWrite.valid),
    .resultValid (resultValid)
);

// File: rtl/dataFolder.sv
module dataFolder (
    input  logic [hisPkg::SAMPLE_W-1:0] sample,
    input  logic                        wrEn,
    input  hisPkg::passT                pass,
    input  hisPkg::windowT              window,
    output hisPkg::binWriteT            binWrite
);
    import hisPkg::*;

    // coarse bin index before truncation
    logic [SAMPLE_W-1:0] coarseShifted;
    // offset of the sample from the window start
    logic [SAMPLE_W-1:0] fineOffset;
    logic                inWindow;

    // top nibble selects the coarse bin
    assign coarseShifted = sample >> COARSE_SHIFT;

    // fine bins are one value wide
    assign fineOffset = sample - window.thMinus;

    // window bounds are inclusive on both ends
    assign inWindow = (sample >= window.thMinus) && (sample <= window.thPositive);

    always_comb begin
        binWrite = '0;
        if (pass == COARSE) begin
            // every sample lands somewhere in the coarse pass
            binWrite.valid = wrEn;
            binWrite.bin   = coarseShifted[BIN_W-1:0];
        end else begin
            // fine pass drops anything outside the window
            binWrite.valid = wrEn && inWindow;
            binWrite.bin   = fineOffset[BIN_W-1:0];
        end
    end

endmodule

// File: rtl/hisBuilder.sv
module hisBuilder (
    input  logic              clk,
    input  logic              arstN,
    input  logic              wrEn,
    input  hisPkg::binWriteT  binWrite,
    output hisPkg::passT      pass,
    output logic              busy,
    output hisPkg::binReadT   binRead
);
    import hisPkg::*;

    hisStateT state;

    // bin counters, one per bin
    logic [COUNT_W-1:0] binCount [NUM_BINS];

    // accepted samples in the current pass
    logic [$clog2(ACQ_LEN)-1:0] acqCount;

    // scan pointer, walks all bins once per scan
    logic [BIN_W-1:0] scanIdx;

    // write captured with wrEn, applied one edge later
    binWriteT pendWrite;

    logic accept;
    logic scanLast;
    // pending increment aimed at the bin being scanned
    logic pendHit;

    // scan states only
    assign busy = (state == COARSE_SCAN) || (state == FINE_SCAN);

    assign pass = ((state == COARSE_ACQ) || (state == COARSE_SCAN)) ? COARSE : FINE;

    // strobes during a scan are dropped
    assign accept = wrEn && !busy;

    assign scanLast = (scanIdx == BIN_W'(NUM_BINS - 1));

    // only the first scan cycle can still see a pending write
    assign pendHit = pendWrite.valid && (pendWrite.bin == scanIdx);

    always_comb begin
        binRead       = '0;
        binRead.valid = busy;
        binRead.pass  = pass;
        binRead.index = scanIdx;
        // forward the late increment so the read is complete
        binRead.count = binCount[scanIdx] + COUNT_W'(pendHit);
        binRead.last  = busy && scanLast;
    end

    // pass state machine and sample counter
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= COARSE_ACQ;
            acqCount <= '0;
            scanIdx  <= '0;
        end else begin
            case (state)
                COARSE_ACQ, FINE_ACQ: begin
                    if (accept) begin
                        if (int'(acqCount) == ACQ_LEN - 1) begin
                            acqCount <= '0;
                            // full pass, go scan
                            state    <= (state == COARSE_ACQ) ? COARSE_SCAN : FINE_SCAN;
                        end else begin
                            acqCount <= acqCount + 1'b1;
                        end
                    end
                end
                COARSE_SCAN, FINE_SCAN: begin
                    // wraps back to 0 after the last bin
                    scanIdx <= scanIdx + 1'b1;
                    if (scanLast) begin
                        state <= (state == COARSE_SCAN) ? FINE_ACQ : COARSE_ACQ;
                    end
                end
                default: begin
                    state <= COARSE_ACQ;
                end
            endcase
        end
    end

    // one stage between capture and increment
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pendWrite <= '0;
        end else begin
            pendWrite.valid <= accept && binWrite.valid;
            pendWrite.bin   <= binWrite.bin;
        end
    end

    // read-and-clear during scan, increment otherwise
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NUM_BINS; i++) begin
                binCount[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_BINS; i++) begin
                if (busy && (scanIdx == BIN_W'(i))) begin
                    // next pass starts empty
                    binCount[i] <= '0;
                end else if (pendWrite.valid && (pendWrite.bin == BIN_W'(i))) begin
                    binCount[i] <= binCount[i] + 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/hisPkg.sv
package hisPkg;

    // raw sample width
    localparam int SAMPLE_W = 8;
    // bins per pass, coarse and fine alike
    localparam int NUM_BINS = 16;
    localparam int BIN_W = 4;
    // one bin can hold a full pass of samples
    localparam int COUNT_W = 6;
    // accepted samples per pass
    localparam int ACQ_LEN = 32;
    // sample to coarse bin, 16 values per bin
    localparam int COARSE_SHIFT = 4;
    // fine window starts half a window below the coarse bin
    localparam int WIN_OFFSET = 8;
    // highest window start so the window stays inside 0..255
    localparam int WIN_MAX = 240;

    typedef enum logic [1:0] {
        COARSE_ACQ,
        COARSE_SCAN,
        FINE_ACQ,
        FINE_SCAN
    } hisStateT;

    typedef enum logic {
        COARSE,
        FINE
    } passT;

    // one bin increment per cycle
    typedef struct packed {
        logic             valid;
        logic [BIN_W-1:0] bin;
    } binWriteT;

    // one scanned bin per cycle
    typedef struct packed {
        logic               valid;
        passT               pass;
        logic [BIN_W-1:0]   index;
        logic [COUNT_W-1:0] count;
        logic               last;
    } binReadT;

    typedef struct packed {
        logic [SAMPLE_W-1:0] thMinus;
        logic [SAMPLE_W-1:0] thPositive;
    } windowT;

    typedef struct packed {
        passT               pass;
        logic [BIN_W-1:0]   bin;
        logic [COUNT_W-1:0] count;
    } peakT;

    typedef struct packed {
        logic [BIN_W-1:0]    coarseBin;
        logic [BIN_W-1:0]    fineBin;
        logic [SAMPLE_W-1:0] estimate;
        logic [COUNT_W-1:0]  peakCount;
    } resultT;

endpackage

// File: rtl/hisTop.sv
module hisTop (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic [hisPkg::SAMPLE_W-1:0] sample,
    input  logic                        wrEn,
    output logic                        busy,
    output logic                        resultValid,
    output hisPkg::resultT              result
);
    import hisPkg::*;

    // current pass from the builder
    passT     pass;
    // fine window from windowCalc
    windowT   window;
    // folded sample into a bin write
    binWriteT binWrite;
    // scanned bins toward the peak search
    binReadT  binRead;
    logic     peakValid;
    peakT     peak;

    dataFolder dataFolder0 (
        .sample   (sample),
        .wrEn     (wrEn),
        .pass     (pass),
        .window   (window),
        .binWrite (binWrite)
    );

    hisBuilder hisBuilder0 (
        .clk      (clk),
        .arstN    (arstN),
        .wrEn     (wrEn),
        .binWrite (binWrite),
        .pass     (pass),
        .busy     (busy),
        .binRead  (binRead)
    );

    peakDetector peakDetector0 (
        .clk       (clk),
        .arstN     (arstN),
        .binRead   (binRead),
        .peakValid (peakValid),
        .peak      (peak)
    );

    // closes the loop back to dataFolder
    windowCalc windowCalc0 (
        .clk         (clk),
        .arstN       (arstN),
        .peakValid   (peakValid),
        .peak        (peak),
        .window      (window),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

// File: rtl/peakDetector.sv
module peakDetector (
    input  logic             clk,
    input  logic             arstN,
    input  hisPkg::binReadT  binRead,
    output logic             peakValid,
    output hisPkg::peakT     peak
);
    import hisPkg::*;

    // set while a scan is in progress
    logic tracking;

    // best bin so far
    logic [BIN_W-1:0]   bestBin;
    logic [COUNT_W-1:0] bestCount;

    // best after taking the current read into account
    logic               takeNew;
    logic [BIN_W-1:0]   candBin;
    logic [COUNT_W-1:0] candCount;

    // strictly greater, so ties keep the lower index
    assign takeNew   = !tracking || (binRead.count > bestCount);
    assign candBin   = takeNew ? binRead.index : bestBin;
    assign candCount = takeNew ? binRead.count : bestCount;

    // control
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tracking  <= 1'b0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= binRead.valid && binRead.last;
            if (binRead.valid) begin
                // first read opens, last read closes
                tracking <= !binRead.last;
            end
        end
    end

    // running best and reported peak
    always_ff @(posedge clk) begin
        if (binRead.valid) begin
            bestBin   <= candBin;
            bestCount <= candCount;
            if (binRead.last) begin
                peak.pass  <= binRead.pass;
                peak.bin   <= candBin;
                peak.count <= candCount;
            end
        end
    end

endmodule

// File: rtl/windowCalc.sv
module windowCalc (
    input  logic            clk,
    input  logic            arstN,
    input  logic            peakValid,
    input  hisPkg::peakT    peak,
    output hisPkg::windowT  window,
    output logic            resultValid,
    output hisPkg::resultT  result
);
    import hisPkg::*;

    // coarse bin kept for the result
    logic [BIN_W-1:0] coarseBin;

    // unclamped window start, may go negative
    int winStart;
    logic [SAMPLE_W-1:0] thMinusNext;

    always_comb begin
        winStart = (int'(peak.bin) << COARSE_SHIFT) - WIN_OFFSET;
        if (winStart < 0) begin
            thMinusNext = '0;
        end else if (winStart > WIN_MAX) begin
            thMinusNext = SAMPLE_W'(WIN_MAX);
        end else begin
            thMinusNext = SAMPLE_W'(winStart);
        end
    end

    // window update on a coarse peak, 0..15 out of reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            window.thMinus    <= '0;
            window.thPositive <= SAMPLE_W'(NUM_BINS - 1);
            coarseBin         <= '0;
            resultValid       <= 1'b0;
        end else begin
            resultValid <= peakValid && (peak.pass == FINE);
            if (peakValid && (peak.pass == COARSE)) begin
                window.thMinus    <= thMinusNext;
                window.thPositive <= thMinusNext + SAMPLE_W'(NUM_BINS - 1);
                coarseBin         <= peak.bin;
            end
        end
    end

    // result on a fine peak
    always_ff @(posedge clk) begin
        if (peakValid && (peak.pass == FINE)) begin
            result.coarseBin <= coarseBin;
            result.fineBin   <= peak.bin;
            result.estimate  <= window.thMinus + SAMPLE_W'(peak.bin);
            result.peakCount <= peak.count;
        end
    end

endmodule

// File: tb.f
rtl/hisPkg.sv
rtl/dataFolder.sv
rtl/hisBuilder.sv
rtl/peakDetector.sv
rtl/windowCalc.sv
rtl/hisTop.sv
bench/hisClockGen.sv
bench/hisTop_props.sv
bench/hisTb.sv
